// ==== vdp_host_subsystem.f ====
+incdir+hw
hw/vdp_pkg.sv
hw/vdp_host_interface.sv
hw/vdp_copper.sv
hw/vdp_register_file.sv
hw/vdp_host_subsystem.sv
sim/vdp_host_subsystem_tb.sv

// ==== sim/vdp_host_cases.txt ====
# op address data expected name, fields in hex, - where unused
# hh puts its second-cycle data in expected, cl is: cl reg data ram_index kind
hr all - 0000 reset_zero
hw 01 1234 - write_basic
hr 01 - 1234 read_basic
hw 1f beef - write_top
hr 1f - beef read_top
hw 00 a5a5 - write_low
hr 00 - a5a5 read_low
hr 01 - 1234 read_basic_again
hh 02 5555 aaaa held_strobe
hr 02 - 5555 held_first_data
hw 05 0505 - host_keep
cl 03 1111 00 write
cl 04 2222 01 write
cl 00 0000 02 stop
fs - - - copper_writes
hr 03 - 1111 copper_reg3
hr 04 - 2222 copper_reg4
hr 05 - 0505 copper_untouched
hr 02 - 5555 copper_untouched_held
hw 07 0707 - before_wait
rl - 0032 - line_50
cl 00 0064 00 wait
cl 07 7777 01 write
cl 00 0000 02 stop
fb - - - wait_busy
hr 07 - 0707 wait_unchanged
rl - 0064 - line_100
hr 07 - 7777 after_wait
hw 0a rnd - rnd_single
hr 0a - rnd rnd_single
hw all rnd - lfsr_sweep
hr all - rnd lfsr_readback

// ==== sim/vdp_host_subsystem_tb.sv ====
/*
 * Testbench for the VDP register front end. Runs the operations listed in
 * sim/vdp_host_cases.txt against the DUT and checks read data and status
 * levels against its own model of the register file.
 */

`timescale 1ns/1ps

`include "vdp_defs.svh"

module vdp_host_subsystem_tb;
    import vdp_pkg::*;

    typedef logic [8*24-1:0] token_t;

    localparam int timeout_cycles = 200;

    logic         clk;
    logic         reset;
    reg_addr_t    host_address;
    logic         host_write_en;
    reg_data_t    host_write_data;
    logic         host_read_en;
    logic         host_ready;
    reg_data_t    host_read_data;
    logic         cop_ram_write_en;
    cop_pc_t      cop_ram_address;
    cop_command_t cop_ram_data;
    logic         frame_start;
    raster_line_t raster_line;
    logic         cop_busy;

    // expected register contents for host writes
    reg_data_t    model [`VDP_REG_COUNT];
    logic [31:0]  lfsr_state;

    vdp_host_subsystem dut0 (
        .clk              (clk),
        .reset            (reset),
        .host_address     (host_address),
        .host_write_en    (host_write_en),
        .host_write_data  (host_write_data),
        .host_read_en     (host_read_en),
        .host_ready       (host_ready),
        .host_read_data   (host_read_data),
        .cop_ram_write_en (cop_ram_write_en),
        .cop_ram_address  (cop_ram_address),
        .cop_ram_data     (cop_ram_data),
        .frame_start      (frame_start),
        .raster_line      (raster_line),
        .cop_busy         (cop_busy)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // fibonacci form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    task automatic random_data(output reg_data_t value);
        for (int i = 0; i < `VDP_DATA_WIDTH; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value[i] = lfsr_state[0];
        end
    endtask

    // a field that is not hex reads as zero
    function automatic logic [31:0] parse_hex(input token_t token);
        logic [31:0] value;
        int          code;
        value = '0;
        code = $sscanf(token, "%h", value);
        return value;
    endfunction

    task automatic abort_run();
        $display("TEST FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_reg_data(input token_t name, input reg_data_t expected,
                                  input reg_data_t actual);
        if (actual !== expected) begin
            $display("MISMATCH %0s expected %h actual %h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_bit(input token_t name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("MISMATCH %0s expected %b actual %b", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic wait_host_ready(input token_t name, input logic level);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (host_ready !== level) begin
            if (cycles >= timeout_cycles) begin
                $display("%0s: host_ready did not reach %b within %0d cycles",
                         name, level, timeout_cycles);
                abort_run();
            end
            cycles++;
            @(negedge clk);
        end
    endtask

    task automatic wait_copper_idle(input token_t name);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (cop_busy !== 1'b0) begin
            if (cycles >= timeout_cycles) begin
                $display("%0s: copper still busy after %0d cycles", name, timeout_cycles);
                abort_run();
            end
            cycles++;
            @(negedge clk);
        end
    endtask

    // hold_data is driven in a second strobe cycle when held is set
    task automatic host_write(input token_t name, input reg_addr_t address,
                              input reg_data_t data, input logic held,
                              input reg_data_t hold_data);
        @(posedge clk);
        host_address    <= address;
        host_write_data <= data;
        host_write_en   <= 1'b1;
        if (held) begin
            @(posedge clk);
            host_write_data <= hold_data;
        end
        @(posedge clk);
        host_write_en <= 1'b0;
        wait_host_ready(name, 1'b1);
        wait_host_ready(name, 1'b0);
        model[address] = data;
    endtask

    task automatic host_read(input token_t name, input reg_addr_t address,
                             input reg_data_t expected);
        @(posedge clk);
        host_address <= address;
        host_read_en <= 1'b1;
        @(posedge clk);
        host_read_en <= 1'b0;
        wait_host_ready(name, 1'b1);
        check_reg_data(name, expected, host_read_data);
        wait_host_ready(name, 1'b0);
    endtask

    task automatic copper_load(input cop_pc_t index, input cop_command_t command);
        @(posedge clk);
        cop_ram_write_en <= 1'b1;
        cop_ram_address  <= index;
        cop_ram_data     <= command;
        @(posedge clk);
        cop_ram_write_en <= 1'b0;
    endtask

    task automatic pulse_frame_start();
        @(posedge clk);
        frame_start <= 1'b1;
        @(posedge clk);
        frame_start <= 1'b0;
    endtask

    task automatic run_case(input token_t op, input token_t addr_tok, input token_t data_tok,
                            input token_t exp_tok, input token_t name);
        int           first;
        int           last;
        reg_data_t    data;
        reg_data_t    expected;
        cop_command_t command;

        first = (addr_tok == "all") ? 0 : int'(parse_hex(addr_tok));
        last  = (addr_tok == "all") ? `VDP_REG_COUNT - 1 : first;
        if (op == "hw") begin
            for (int a = first; a <= last; a++) begin
                if (data_tok == "rnd")
                    random_data(data);
                else
                    data = reg_data_t'(parse_hex(data_tok));
                host_write(name, reg_addr_t'(a), data, 1'b0, '0);
            end
        end else if (op == "hh") begin
            host_write(name, reg_addr_t'(first), reg_data_t'(parse_hex(data_tok)), 1'b1,
                       reg_data_t'(parse_hex(exp_tok)));
        end else if (op == "hr") begin
            for (int a = first; a <= last; a++) begin
                expected = (exp_tok == "rnd") ? model[a] : reg_data_t'(parse_hex(exp_tok));
                host_read(name, reg_addr_t'(a), expected);
            end
        end else if (op == "cl") begin
            command.address = reg_addr_t'(first);
            command.data    = reg_data_t'(parse_hex(data_tok));
            // the last column names the command kind for program words
            if (name == "write") begin
                command.op = `VDP_COP_OP_WRITE;
            end else if (name == "wait") begin
                command.op = `VDP_COP_OP_WAIT;
            end else if (name == "stop") begin
                command.op = `VDP_COP_OP_STOP;
            end else begin
                $display("unknown copper command kind %0s", name);
                abort_run();
            end
            copper_load(cop_pc_t'(parse_hex(exp_tok)), command);
        end else if (op == "rl") begin
            @(posedge clk);
            raster_line <= raster_line_t'(parse_hex(data_tok));
            wait_copper_idle(name);
        end else if (op == "fs") begin
            pulse_frame_start();
            wait_copper_idle(name);
        end else if (op == "fb") begin
            pulse_frame_start();
            repeat (20) @(negedge clk);
            check_bit(name, 1'b1, cop_busy);
        end else begin
            $display("unknown operation %0s in the case file", op);
            abort_run();
        end
    endtask

    initial begin
        int               fd;
        int               code;
        token_t           op;
        token_t           addr_tok;
        token_t           data_tok;
        token_t           exp_tok;
        token_t           name;
        logic [8*128-1:0] rest;

        reset            = 1'b1;
        host_address     = '0;
        host_write_en    = 1'b0;
        host_write_data  = '0;
        host_read_en     = 1'b0;
        cop_ram_write_en = 1'b0;
        cop_ram_address  = '0;
        cop_ram_data     = '0;
        frame_start      = 1'b0;
        raster_line      = '0;
        lfsr_state       = 32'h5da9;
        for (int i = 0; i < `VDP_REG_COUNT; i++) begin
            model[i] = '0;
        end

        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_bit("reset_ready", 1'b0, host_ready);
        check_bit("reset_busy", 1'b0, cop_busy);

        fd = $fopen("sim/vdp_host_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open sim/vdp_host_cases.txt");
            abort_run();
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", op);
            if (code == 1 && op == "#") begin
                code = $fgets(rest, fd);
            end else if (code == 1) begin
                code = $fscanf(fd, "%s %s %s %s", addr_tok, data_tok, exp_tok, name);
                if (code != 4) begin
                    $display("incomplete case line for operation %0s", op);
                    abort_run();
                end
                run_case(op, addr_tok, data_tok, exp_tok, name);
            end
        end
        $fclose(fd);

        $display("TEST PASS");
        $finish;
    end

endmodule

// ==== hw/vdp_host_subsystem.sv ====
/*
 * Top of the VDP register front end. Connects the host interface, the
 * copper and the register file. The CPU bus, the copper load port and the
 * frame timing inputs come straight from the outside.
 */

`timescale 1ns/1ps

module vdp_host_subsystem (
    input  logic                    clk,
    input  logic                    reset,

    // CPU bus
    input  vdp_pkg::reg_addr_t      host_address,
    input  logic                    host_write_en,
    input  vdp_pkg::reg_data_t      host_write_data,
    input  logic                    host_read_en,
    output logic                    host_ready,
    output vdp_pkg::reg_data_t      host_read_data,

    // copper program load
    input  logic                    cop_ram_write_en,
    input  vdp_pkg::cop_pc_t        cop_ram_address,
    input  vdp_pkg::cop_command_t   cop_ram_data,

    // frame timing
    input  logic                    frame_start,
    input  vdp_pkg::raster_line_t   raster_line,
    output logic                    cop_busy
);
    import vdp_pkg::*;

    logic       cop_write_en;
    reg_addr_t  cop_write_address;
    reg_data_t  cop_write_data;
    reg_write_t reg_write;
    reg_addr_t  read_address;
    reg_data_t  read_data;

    vdp_host_interface host_interface0 (
        .clk               (clk),
        .reset             (reset),
        .host_address      (host_address),
        .host_write_en     (host_write_en),
        .host_write_data   (host_write_data),
        .host_read_en      (host_read_en),
        .cop_write_en      (cop_write_en),
        .cop_write_address (cop_write_address),
        .cop_write_data    (cop_write_data),
        .reg_write         (reg_write),
        .read_address      (read_address),
        .ready             (host_ready)
    );

    vdp_copper copper0 (
        .clk           (clk),
        .reset         (reset),
        .ram_write_en  (cop_ram_write_en),
        .ram_address   (cop_ram_address),
        .ram_data      (cop_ram_data),
        .frame_start   (frame_start),
        .raster_line   (raster_line),
        .write_en      (cop_write_en),
        .write_address (cop_write_address),
        .write_data    (cop_write_data),
        .busy          (cop_busy)
    );

    vdp_register_file register_file0 (
        .clk          (clk),
        .reset        (reset),
        .reg_write    (reg_write),
        .read_address (read_address),
        .read_data    (read_data)
    );

    assign host_read_data = read_data;

endmodule

// ==== hw/vdp_register_file.sv ====
/*
 * VDP register storage. One write port fed by the host interface and a
 * combinational read port addressed by the registered host read address.
 */

`timescale 1ns/1ps

`include "vdp_defs.svh"

module vdp_register_file (
    input  logic                  clk,
    input  logic                  reset,

    input  vdp_pkg::reg_write_t   reg_write,
    input  vdp_pkg::reg_addr_t    read_address,
    output vdp_pkg::reg_data_t    read_data
);
    import vdp_pkg::*;

    reg_data_t registers [`VDP_REG_COUNT];

    // all registers read as zero after reset
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `VDP_REG_COUNT; i++) begin
                registers[i] <= '0;
            end
        end else if (reg_write.en) begin
            registers[reg_write.address] <= reg_write.data;
        end
    end

    // no read latency, data follows read_address directly
    assign read_data = registers[read_address];

endmodule

// ==== hw/vdp_copper.sv ====
/*
 * Display copper. Holds a small program RAM loaded through its own port and
 * runs the program once per frame_start, issuing register writes and
 * stalling on raster waits. busy stays high until the last strobe is out.
 */

`timescale 1ns/1ps

`include "vdp_defs.svh"

module vdp_copper (
    input  logic                    clk,
    input  logic                    reset,

    // program load port
    input  logic                    ram_write_en,
    input  vdp_pkg::cop_pc_t        ram_address,
    input  vdp_pkg::cop_command_t   ram_data,

    // frame timing
    input  logic                    frame_start,
    input  vdp_pkg::raster_line_t   raster_line,

    // register write strobes toward the host interface
    output logic                    write_en,
    output vdp_pkg::reg_addr_t      write_address,
    output vdp_pkg::reg_data_t      write_data,
    output logic                    busy
);
    import vdp_pkg::*;

    localparam cop_pc_t last_pc = cop_pc_t'(`VDP_COP_RAM_DEPTH - 1);

    cop_command_t program_ram [`VDP_COP_RAM_DEPTH];
    cop_command_t command;
    cop_state_t   state;
    cop_pc_t      pc;
    raster_line_t wait_target;
    logic         at_last;

    always_ff @(posedge clk) begin
        if (ram_write_en) begin
            program_ram[ram_address] <= ram_data;
        end
    end

    // synchronous read, only refreshed in fetch so the word holds during a wait
    always_ff @(posedge clk) begin
        if (state == cop_fetch) begin
            command <= program_ram[pc];
        end
    end

    assign wait_target = command.data[`VDP_RASTER_WIDTH-1:0];
    assign at_last     = (pc == last_pc);

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= cop_idle;
            pc       <= '0;
            write_en <= 1'b0;
        end else begin
            write_en <= 1'b0;

            if (frame_start) begin
                // restart from the top, even mid program
                state <= cop_fetch;
                pc    <= '0;
            end else begin
                case (state)
                    cop_idle: begin
                        state <= cop_idle;
                    end

                    cop_fetch: begin
                        state <= cop_exec;
                    end

                    cop_exec: begin
                        case (command.op)
                            `VDP_COP_OP_WRITE: begin
                                write_en <= 1'b1;
                                pc       <= pc + 1'b1;
                                state    <= at_last ? cop_idle : cop_fetch;
                            end
                            `VDP_COP_OP_WAIT: begin
                                state <= cop_wait_line;
                            end
                            // stop, and the unused opcode ends the program too
                            default: begin
                                state <= cop_idle;
                            end
                        endcase
                    end

                    cop_wait_line: begin
                        if (raster_line >= wait_target) begin
                            pc    <= pc + 1'b1;
                            state <= at_last ? cop_idle : cop_fetch;
                        end
                    end

                    default: begin
                        state <= cop_idle;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == cop_exec && command.op == `VDP_COP_OP_WRITE) begin
            write_address <= command.address;
            write_data    <= command.data;
        end
    end

    // held through the final strobe so a falling busy means all writes issued
    assign busy = (state != cop_idle) || write_en;

endmodule

// ==== hw/vdp_host_interface.sv ====
/*
 * Host bus front end. Registers the CPU strobes, turns a rising write strobe
 * into one register write, merges in copper writes with the CPU taking
 * priority, and returns a one-cycle ready pulse per registered strobe.
 */

`timescale 1ns/1ps

module vdp_host_interface (
    input  logic                  clk,
    input  logic                  reset,

    // CPU side
    input  vdp_pkg::reg_addr_t    host_address,
    input  logic                  host_write_en,
    input  vdp_pkg::reg_data_t    host_write_data,
    input  logic                  host_read_en,

    // copper side, plain one-cycle strobes
    input  logic                  cop_write_en,
    input  vdp_pkg::reg_addr_t    cop_write_address,
    input  vdp_pkg::reg_data_t    cop_write_data,

    // register file side
    output vdp_pkg::reg_write_t   reg_write,
    output vdp_pkg::reg_addr_t    read_address,
    output logic                  ready
);
    import vdp_pkg::*;

    logic      host_write_en_r;
    logic      host_read_en_r;
    reg_addr_t host_address_r;

    logic      host_write_rise;
    logic      write_en_q;
    reg_addr_t write_address_q;
    reg_data_t write_data_q;

    // only the first cycle of a held write strobe counts
    assign host_write_rise = host_write_en && !host_write_en_r;

    always_ff @(posedge clk) begin
        if (reset) begin
            host_write_en_r <= 1'b0;
            host_read_en_r  <= 1'b0;
        end else begin
            host_write_en_r <= host_write_en;
            host_read_en_r  <= host_read_en;
        end
    end

    always_ff @(posedge clk) begin
        host_address_r <= host_address;
    end

    // one wait cycle from the registered strobes, nothing more
    always_ff @(posedge clk) begin
        if (reset) begin
            ready <= 1'b0;
        end else begin
            ready <= host_write_en_r || host_read_en_r;
        end
    end

    // reads are never blocked by writes
    always_ff @(posedge clk) begin
        read_address <= host_address_r;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            write_en_q <= 1'b0;
        end else begin
            write_en_q <= host_write_rise || cop_write_en;
        end
    end

    // cpu wins a same-cycle conflict, the copper write is dropped
    always_ff @(posedge clk) begin
        if (host_write_rise) begin
            write_address_q <= host_address;
            write_data_q    <= host_write_data;
        end else if (cop_write_en) begin
            write_address_q <= cop_write_address;
            write_data_q    <= cop_write_data;
        end
    end

    assign reg_write = '{
        en:      write_en_q,
        address: write_address_q,
        data:    write_data_q
    };

endmodule

// ==== hw/vdp_pkg.sv ====
/*
 * Shared types of the VDP register front end: width typedefs, the copper
 * program word, the register-file write and the copper state encoding.
 */

`include "vdp_defs.svh"

package vdp_pkg;

    typedef logic [$clog2(`VDP_REG_COUNT)-1:0]     reg_addr_t;
    typedef logic [`VDP_DATA_WIDTH-1:0]            reg_data_t;
    typedef logic [`VDP_RASTER_WIDTH-1:0]          raster_line_t;
    typedef logic [$clog2(`VDP_COP_RAM_DEPTH)-1:0] cop_pc_t;
    typedef logic [1:0]                            cop_op_t;

    // one copper program word
    // for a wait, the low raster bits of data hold the target line
    typedef struct packed {
        cop_op_t   op;
        reg_addr_t address;
        reg_data_t data;
    } cop_command_t;

    // single write into the register file
    typedef struct packed {
        logic      en;
        reg_addr_t address;
        reg_data_t data;
    } reg_write_t;

    typedef enum logic [1:0] {
        cop_idle,
        cop_fetch,
        cop_exec,
        cop_wait_line
    } cop_state_t;

endpackage

// ==== hw/vdp_defs.svh ====
/*
 * Size and opcode macros for the VDP register front end.
 * Included by the package, the RTL and the testbench that builds copper programs.
 */

`ifndef VDP_DEFS_SVH
`define VDP_DEFS_SVH

// register file geometry
`define VDP_REG_COUNT      32
`define VDP_DATA_WIDTH     16

// copper program RAM and raster counter
`define VDP_COP_RAM_DEPTH  64
`define VDP_RASTER_WIDTH   9

// copper opcodes, two bits in each program word
`define VDP_COP_OP_WRITE   2'd0
`define VDP_COP_OP_WAIT    2'd1
`define VDP_COP_OP_STOP    2'd2

`endif
